// ==== pnGenPkg.sv ====
package pnGenPkg;

    // Widths
    localparam int polyWidth = 24;
    localparam int lenWidth = 5;
    localparam int rateWidth = 32;
    localparam int adrWidth = 4;
    localparam int dataWidth = 32;

    // Word addresses
    localparam logic [adrWidth-1:0] regCtrl = 4'd0;
    localparam logic [adrWidth-1:0] regTaps = 4'd1;
    localparam logic [adrWidth-1:0] regLength = 4'd2;
    localparam logic [adrWidth-1:0] regRate = 4'd3;

    // Control register fields
    localparam int ctrlEnable = 0;
    localparam int ctrlRestart = 1;      // Self-clearing
    localparam int ctrlInject = 2;       // Self-clearing
    localparam int ctrlInject1E3 = 3;
    localparam int ctrlMirror = 4;
    localparam int ctrlInvert = 5;
    localparam int ctrlPcmLsb = 8;       // Two bit PCM code

    localparam int injectPeriod = 1000;
    localparam int injectCntWidth = $clog2(injectPeriod);

    localparam logic [polyWidth-1:0] lfsrSeed = {polyWidth{1'b1}};

    typedef enum logic [1:0] {
        pcmNrzL,
        pcmNrzM,
        pcmNrzS,
        pcmBiphaseL
    } pcmCode_t;

    typedef enum logic [1:0] {
        seqIdle,
        seqSeed,
        seqRun
    } seqState_t;

endpackage

// ==== pnGenCfgIf.sv ====
`timescale 1ns/1ps

interface pnGenCfgIf;
    import pnGenPkg::*;

    logic [polyWidth-1:0] taps;
    logic [lenWidth-1:0] length;
    logic mirror;
    logic [rateWidth-1:0] rate;
    pcmCode_t pcmCode;
    logic invert;
    logic enable;

    modport regs (output taps, length, mirror, rate, pcmCode, invert, enable);

    modport timer (input rate, pcmCode);

    modport seq (input enable);

    modport lfsr (input taps, length, mirror);

    modport enc (input pcmCode, invert);

endinterface

// ==== pnGenRegs.sv ====
`timescale 1ns/1ps

module pnGenRegs (
    input logic clk,
    input logic reset,
    input logic wbCyc,
    input logic wbStb,
    input logic wbWe,
    input logic [pnGenPkg::adrWidth-1:0] wbAdr,
    input logic [pnGenPkg::dataWidth-1:0] wbDatW,
    output logic [pnGenPkg::dataWidth-1:0] wbDatR,
    output logic wbAck,
    pnGenCfgIf.regs cfg,
    output logic restartPulse,
    output logic injectPulse,
    output logic inject1E3
);
    import pnGenPkg::*;

    logic req;
    logic ctrlWrite;
    logic [dataWidth-1:0] readData;

    assign req = wbCyc & wbStb & ~wbAck;  // No wait states
    assign ctrlWrite = req & wbWe & (wbAdr == regCtrl);

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
            restartPulse <= 1'b0;
            injectPulse <= 1'b0;
            inject1E3 <= 1'b0;
            cfg.enable <= 1'b0;
            cfg.mirror <= 1'b0;
            cfg.invert <= 1'b0;
            cfg.pcmCode <= pcmNrzL;
            cfg.taps <= '0;
            cfg.length <= '0;
            cfg.rate <= '0;
        end else begin
            wbAck <= req;
            restartPulse <= ctrlWrite & wbDatW[ctrlRestart];
            injectPulse <= ctrlWrite & wbDatW[ctrlInject];
            if (req && wbWe) begin
                case (wbAdr)
                    regCtrl: begin
                        cfg.enable <= wbDatW[ctrlEnable];
                        inject1E3 <= wbDatW[ctrlInject1E3];
                        cfg.mirror <= wbDatW[ctrlMirror];
                        cfg.invert <= wbDatW[ctrlInvert];
                        cfg.pcmCode <= pcmCode_t'(wbDatW[ctrlPcmLsb +: $bits(pcmCode_t)]);
                    end
                    regTaps: cfg.taps <= wbDatW[polyWidth-1:0];
                    regLength: cfg.length <= wbDatW[lenWidth-1:0];
                    regRate: cfg.rate <= wbDatW[rateWidth-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Command bits read back as 0
    always_comb begin
        readData = '0;
        case (wbAdr)
            regCtrl: begin
                readData[ctrlEnable] = cfg.enable;
                readData[ctrlInject1E3] = inject1E3;
                readData[ctrlMirror] = cfg.mirror;
                readData[ctrlInvert] = cfg.invert;
                readData[ctrlPcmLsb +: $bits(pcmCode_t)] = cfg.pcmCode;
            end
            regTaps: readData[polyWidth-1:0] = cfg.taps;
            regLength: readData[lenWidth-1:0] = cfg.length;
            regRate: readData[rateWidth-1:0] = cfg.rate;
            default: readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wbDatR <= readData;  // Valid with ack
        end
    end

endmodule

// ==== pnGenRate.sv ====
`timescale 1ns/1ps

module pnGenRate (
    input logic clk,
    input logic reset,
    pnGenCfgIf.timer cfg,
    input logic enable,
    output logic symEn,
    output logic bitEn,
    output logic pnClk
);
    import pnGenPkg::*;

    logic [rateWidth-1:0] phase;
    logic [rateWidth:0] phaseSum;
    logic carry;
    logic half;  // Second symbol of a biphase bit

    assign phaseSum = {1'b0, phase} + {1'b0, cfg.rate};
    assign carry = phaseSum[rateWidth];
    assign pnClk = phase[rateWidth-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            symEn <= 1'b0;
            bitEn <= 1'b0;
            half <= 1'b0;
        end else begin
            phase <= phaseSum[rateWidth-1:0];
            symEn <= carry;
            bitEn <= carry & ((cfg.pcmCode != pcmBiphaseL) | half);
            if (!enable) begin
                half <= 1'b0;  // Keeps halving aligned to enable
            end else if (carry) begin
                half <= ~half;
            end
        end
    end

endmodule

// ==== pnGenSeq.sv ====
`timescale 1ns/1ps

module pnGenSeq (
    input logic clk,
    input logic reset,
    pnGenCfgIf.seq cfg,
    input logic bitEn,
    input logic restartPulse,
    input logic injectPulse,
    input logic inject1E3,
    output logic load,
    output logic step,
    output logic flip
);
    import pnGenPkg::*;

    seqState_t state;
    logic pending;
    logic injectNow;
    logic periodicHit;
    logic [injectCntWidth-1:0] count;

    assign injectNow = pending | injectPulse;
    assign periodicHit = inject1E3 && (count == '0);
    assign load = (state == seqSeed);
    assign step = (state == seqRun) && bitEn;
    assign flip = step && (injectNow || periodicHit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seqIdle;
        end else if (!cfg.enable) begin
            state <= seqIdle;
        end else if (restartPulse) begin
            state <= seqSeed;  // Reseed from any state
        end else begin
            case (state)
                seqIdle: state <= seqSeed;
                seqSeed: state <= seqRun;
                default: state <= seqRun;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            count <= '0;
        end else begin
            pending <= injectNow & ~step;  // Consumed by the next step
            if (!inject1E3) begin
                count <= '0;
            end else if (step) begin
                count <= (count == '0) ? injectCntWidth'(injectPeriod - 1) : count - 1'b1;
            end
        end
    end

endmodule

// ==== pnGenLfsr.sv ====
`timescale 1ns/1ps

module pnGenLfsr (
    input logic clk,
    input logic reset,
    pnGenCfgIf.lfsr cfg,
    input logic load,
    input logic step,
    input logic flip,
    output logic nrzBit
);
    import pnGenPkg::*;

    logic [lenWidth-1:0] lenClamp;
    logic [polyWidth-1:0] lenMask;
    logic [polyWidth-1:0] effTaps;
    logic [polyWidth-1:0] state;
    logic [polyWidth-1:0] nextState;
    logic outBit;

    assign lenClamp = (cfg.length > polyWidth) ? lenWidth'(polyWidth) : cfg.length;

    always_comb begin
        lenMask = '0;
        effTaps = cfg.taps;
        if (cfg.mirror) begin
            effTaps = '0;
        end
        for (int i = 0; i < polyWidth; i++) begin
            if (i < lenClamp) begin
                lenMask[i] = 1'b1;
                if (cfg.mirror) begin
                    effTaps[lenClamp - 1 - i] = cfg.taps[i];  // Reverse within length
                end
            end
        end
    end

    // Stuck at zero gets the seed back
    assign nextState = (state == '0) ? lfsrSeed
                                     : {state[polyWidth-2:0], ^(state & effTaps)} & lenMask;

    always_comb begin
        outBit = 1'b0;
        for (int i = 0; i < polyWidth; i++) begin
            if (i == lenClamp - 1) begin
                outBit = nextState[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
            nrzBit <= 1'b0;
        end else if (load) begin
            state <= lfsrSeed;
        end else if (step) begin
            state <= nextState;
            nrzBit <= outBit ^ flip;  // Error injection
        end
    end

endmodule

// ==== pnGenEncoder.sv ====
`timescale 1ns/1ps

module pnGenEncoder (
    input logic clk,
    input logic reset,
    pnGenCfgIf.enc cfg,
    input logic symEn,
    input logic bitEn,
    input logic nrzBit,
    output logic pnBit
);
    import pnGenPkg::*;

    logic level;      // Line level before inversion
    logic nextLevel;

    always_comb begin
        case (cfg.pcmCode)
            pcmNrzL: nextLevel = nrzBit;
            pcmNrzM: nextLevel = level ^ nrzBit;    // Toggle on a one
            pcmNrzS: nextLevel = level ^ ~nrzBit;   // Toggle on a zero
            // bitEn marks the second symbol of the bit
            pcmBiphaseL: nextLevel = nrzBit ^ bitEn;
            default: nextLevel = nrzBit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            level <= 1'b0;
            pnBit <= 1'b0;
        end else if (symEn) begin
            level <= nextLevel;
            pnBit <= nextLevel ^ cfg.invert;
        end
    end

endmodule

// ==== pnGenTop.sv ====
`timescale 1ns/1ps

module pnGenTop (
    input logic clk,
    input logic reset,
    input logic wbCyc,
    input logic wbStb,
    input logic wbWe,
    input logic [pnGenPkg::adrWidth-1:0] wbAdr,
    input logic [pnGenPkg::dataWidth-1:0] wbDatW,
    output logic [pnGenPkg::dataWidth-1:0] wbDatR,
    output logic wbAck,
    output logic pnClkEn,
    output logic pnClk,
    output logic nrzBit,
    output logic pnBit
);

    logic restartPulse;
    logic injectPulse;
    logic inject1E3;
    logic bitEn;
    logic load;
    logic step;
    logic flip;

    pnGenCfgIf cfgIf ();

    pnGenRegs pnGenRegs_inst (
        .clk(clk),
        .reset(reset),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .cfg(cfgIf.regs),
        .restartPulse(restartPulse),
        .injectPulse(injectPulse),
        .inject1E3(inject1E3)
    );

    // Symbol enable goes straight out as pnClkEn
    pnGenRate pnGenRate_inst (
        .clk(clk),
        .reset(reset),
        .cfg(cfgIf.timer),
        .enable(cfgIf.enable),
        .symEn(pnClkEn),
        .bitEn(bitEn),
        .pnClk(pnClk)
    );

    pnGenSeq pnGenSeq_inst (
        .clk(clk),
        .reset(reset),
        .cfg(cfgIf.seq),
        .bitEn(bitEn),
        .restartPulse(restartPulse),
        .injectPulse(injectPulse),
        .inject1E3(inject1E3),
        .load(load),
        .step(step),
        .flip(flip)
    );

    pnGenLfsr pnGenLfsr_inst (
        .clk(clk),
        .reset(reset),
        .cfg(cfgIf.lfsr),
        .load(load),
        .step(step),
        .flip(flip),
        .nrzBit(nrzBit)
    );

    pnGenEncoder pnGenEncoder_inst (
        .clk(clk),
        .reset(reset),
        .cfg(cfgIf.enc),
        .symEn(pnClkEn),
        .bitEn(bitEn),
        .nrzBit(nrzBit),
        .pnBit(pnBit)
    );

endmodule

// ==== pnGen_assert.sv ====
`timescale 1ns/1ps

module pnGenAssert (
    input logic clk,
    input logic reset,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic pnClkEn,
    input logic pnBit,
    input logic [31:0] rate,
    input pnGenPkg::seqState_t seqState
);
    import pnGenPkg::*;

    int failCount = 0;

    // Ack only one cycle after a strobe
    ackAfterStb: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> $past(wbCyc && wbStb) && !$past(wbAck))
        else begin
            failCount++;
            $error("wbAck without a strobe one cycle before");
        end

    symSpacing: assert property (@(posedge clk) disable iff (reset || rate != 32'h4000_0000)
        pnClkEn |=> !pnClkEn [*3] ##1 pnClkEn)
        else begin
            failCount++;
            $error("symEn not spaced four cycles at rate 2^30");
        end

    pnBitHold: assert property (@(posedge clk) disable iff (reset)
        !$past(pnClkEn) |-> $stable(pnBit))
        else begin
            failCount++;
            $error("pnBit changed between symEn pulses");
        end

    seedOneCycle: assert property (@(posedge clk) disable iff (reset)
        seqState == seqSeed |=> seqState != seqSeed)
        else begin
            failCount++;
            $error("seqSeed lasted more than one cycle");
        end

endmodule

bind pnGenTop pnGenAssert pnGenAssert_inst (
    .clk(clk),
    .reset(reset),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAck(wbAck),
    .pnClkEn(pnClkEn),
    .pnBit(pnBit),
    .rate(cfgIf.rate),
    .seqState(pnGenSeq_inst.state)
);

// ==== pnGenTb.sv ====
`timescale 1ns/1ps

module pnGenTb;
    import pnGenPkg::*;

    // Tests run about 23000 cycles in total, the periodic injection alone 12000
    localparam int cycleLimit = 40000;
    localparam logic [31:0] rateQuarter = 32'h4000_0000;

    logic clk;
    logic reset;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [3:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;
    logic pnClkEn;
    logic pnClk;
    logic nrzBit;
    logic pnBit;

    integer seed;
    int cycles;
    logic rateIsQuarter;

    // Reference model
    logic modelOn;
    logic [23:0] mTaps;
    int mLen;
    logic mMirror;
    pcmCode_t mCode;
    logic mInvert;
    logic [23:0] mState;
    logic expNrz;
    logic expPn;
    logic mLevel;
    logic mHalf;
    logic mPending;
    logic mPeriodic;
    int mCount;
    int bitCount;

    pnGenTop pnGenTop_inst (
        .clk(clk),
        .reset(reset),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .pnClkEn(pnClkEn),
        .pnClk(pnClk),
        .nrzBit(nrzBit),
        .pnBit(pnBit)
    );

    always #4 clk = ~clk;

    task automatic abortRun;
        $display("Something failed");
        $fatal(1, "Run stopped on first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    always @(posedge clk) begin
        if (pnGenTop_inst.pnGenAssert_inst.failCount != 0) begin
            $display("A bound assertion on the DUT failed");
            abortRun();
        end
    end

    // Next LFSR state after the shift rule
    function automatic logic [23:0] modelStep(input logic [23:0] s);
        logic [23:0] taps;
        logic fb;
        logic [23:0] n;
        if (s == '0) begin
            return lfsrSeed;
        end
        taps = mMirror ? 24'd0 : mTaps;
        fb = 1'b0;
        for (int i = 0; i < mLen; i++) begin
            if (mMirror) begin
                taps[i] = mTaps[mLen - 1 - i];
            end
        end
        for (int i = 0; i < 24; i++) begin
            if (taps[i]) begin
                fb = fb ^ s[i];
            end
        end
        n = {s[22:0], fb};
        for (int i = mLen; i < 24; i++) begin
            n[i] = 1'b0;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        logic bitNow;
        logic lvl;
        logic flipNow;
        logic [23:0] nextSt;
        if (modelOn && pnClkEn) begin
            bitNow = (mCode != pcmBiphaseL) || mHalf;
            case (mCode)
                pcmNrzL: lvl = expNrz;
                pcmNrzM: lvl = mLevel ^ expNrz;
                pcmNrzS: lvl = mLevel ^ ~expNrz;
                default: lvl = expNrz ^ bitNow;  // Second half is the complement
            endcase
            mLevel <= lvl;
            expPn <= lvl ^ mInvert;
            mHalf <= ~mHalf;
            if (bitNow) begin
                nextSt = modelStep(mState);
                flipNow = mPending || (mPeriodic && mCount == 0);
                mState <= nextSt;
                expNrz <= nextSt[mLen - 1] ^ flipNow;
                mPending <= 1'b0;
                if (mPeriodic) begin
                    mCount <= (mCount == 0) ? injectPeriod - 1 : mCount - 1;
                end
                bitCount <= bitCount + 1;
            end
        end
    end

    nrzCheck: assert property (@(posedge clk) disable iff (!modelOn) nrzBit == expNrz)
        else begin
            $display("[ERROR] %0t nrzBit expected %0b actual %0b",
                     $time, $sampled(expNrz), $sampled(nrzBit));
            abortRun();
        end

    pnCheck: assert property (@(posedge clk) disable iff (!modelOn) pnBit == expPn)
        else begin
            $display("[ERROR] %0t pnBit expected %0b actual %0b",
                     $time, $sampled(expPn), $sampled(pnBit));
            abortRun();
        end

    // Phase MSB over one symbol at rate 2^30, symEn lands on phase zero
    pnClkCheck: assert property (@(posedge clk) disable iff (reset || !rateIsQuarter)
        pnClkEn |-> !pnClk ##1 !pnClk ##1 pnClk ##1 pnClk)
        else begin
            $display("[ERROR] %0t pnClk expected %0b actual %0b",
                     $time, !$sampled(pnClk), $sampled(pnClk));
            abortRun();
        end

    task automatic waitAck;
        int n;
        n = 0;
        while (!wbAck) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 4) begin
                $display("No Wishbone ack within 4 cycles of a strobe");
                abortRun();
            end
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic busWrite(input logic [3:0] adr, input logic [31:0] data);
        @(posedge clk);
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = adr;
        wbDatW = data;
        waitAck();
        if (adr == regRate) begin
            rateIsQuarter = (data == rateQuarter);
        end
    endtask

    task automatic busRead(input logic [3:0] adr, input logic [31:0] expected);
        @(posedge clk);
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = adr;
        waitAck();
        assert (wbDatR == expected)
            else begin
                $display("[ERROR] %0t wbDatR expected %h actual %h", $time, expected, wbDatR);
                abortRun();
            end
    endtask

    task automatic resetDut;
        modelOn = 1'b0;
        rateIsQuarter = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        expNrz = 1'b0;
        expPn = 1'b0;
        mLevel = 1'b0;
        mHalf = 1'b0;
        mPending = 1'b0;
        mPeriodic = 1'b0;
        mCount = 0;
        bitCount = 0;
    endtask

    function automatic logic [31:0] ctrlWord();
        logic [31:0] w;
        w = '0;
        w[ctrlEnable] = 1'b1;
        w[ctrlMirror] = mMirror;
        w[ctrlInvert] = mInvert;
        w[ctrlPcmLsb +: 2] = mCode;
        return w;
    endfunction

    task automatic startRun(input logic [23:0] t, input logic mir, input pcmCode_t code,
                            input logic inv);
        resetDut();
        mTaps = t;
        mLen = 24;
        mMirror = mir;
        mCode = code;
        mInvert = inv;
        busWrite(regTaps, {8'd0, t});
        busWrite(regLength, 32'd24);
        busWrite(regCtrl, ctrlWord());
        repeat (3) @(posedge clk);
        #1;
        mState = lfsrSeed;  // DUT seeded by now, rate still 0
        modelOn = 1'b1;
        busWrite(regRate, rateQuarter);
    endtask

    task automatic waitBits(input int n);
        int target;
        target = bitCount + n;
        while (bitCount < target) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic runWithRestart(input logic [23:0] t, input logic mir);
        logic [31:0] w;
        startRun(t, mir, pcmNrzL, 1'b0);
        waitBits(200);
        busWrite(regRate, 32'd0);
        repeat (6) @(posedge clk);
        w = ctrlWord();
        w[ctrlRestart] = 1'b1;
        busWrite(regCtrl, w);
        repeat (3) @(posedge clk);
        #1;
        mState = lfsrSeed;
        busWrite(regRate, rateQuarter);
        waitBits(200);
    endtask

    initial begin
        logic [23:0] randTaps;
        logic [31:0] w;
        int pulses;
        longint expPulses;
        clk = 1'b0;
        reset = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        modelOn = 1'b0;
        cycles = 0;
        seed = 61;
        mMirror = 1'b0;
        mInvert = 1'b0;
        mCode = pcmNrzL;

        // Register access
        resetDut();
        randTaps = $random(seed);
        busWrite(regTaps, {8'd0, randTaps});
        busWrite(regLength, 32'd24);
        busWrite(regRate, 32'h1234_5678);
        w = 32'h0000_023F;  // Every control bit, NRZ-S
        busWrite(regCtrl, w);
        busRead(regTaps, {8'd0, randTaps});
        busRead(regLength, 32'd24);
        busRead(regRate, 32'h1234_5678);
        busRead(regCtrl, 32'h0000_0239);
        busRead(4'd7, 32'd0);

        // Sequences
        runWithRestart(24'hC0_0000, 1'b0);
        runWithRestart(24'hC0_0000, 1'b1);
        randTaps = $random(seed);
        runWithRestart(randTaps, 1'b0);
        runWithRestart(randTaps, 1'b1);

        // Rate
        resetDut();
        busWrite(regRate, rateQuarter);
        repeat (40) @(posedge clk);
        busWrite(regRate, 32'h0A3D_70A4);
        repeat (8) @(posedge clk);
        pulses = 0;
        repeat (2000) begin
            @(posedge clk);
            if (pnClkEn) begin
                pulses++;
            end
        end
        expPulses = (64'd2000 * 64'h0A3D_70A4) >> 32;
        assert (pulses >= expPulses - 1 && pulses <= expPulses + 1)
            else begin
                $display("[ERROR] %0t pnClkEn count expected %0d actual %0d",
                         $time, expPulses, pulses);
                abortRun();
            end

        // Single injection
        randTaps = $random(seed);
        startRun(randTaps, 1'b0, pcmNrzL, 1'b0);
        waitBits(20);
        w = ctrlWord();
        w[ctrlInject] = 1'b1;
        busWrite(regCtrl, w);
        mPending = 1'b1;
        waitBits(20);

        // Periodic injection
        startRun(randTaps, 1'b1, pcmNrzL, 1'b0);
        waitBits(10);
        w = ctrlWord();
        w[ctrlInject1E3] = 1'b1;
        busWrite(regCtrl, w);
        mCount = 0;
        mPeriodic = 1'b1;
        waitBits(3000);

        // PCM codes
        for (int c = 0; c < 4; c++) begin
            for (int inv = 0; inv < 2; inv++) begin
                startRun(24'hC0_0000, 1'b0, pcmCode_t'(c), inv[0]);
                waitBits(32);
            end
        end

        modelOn = 1'b0;
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== pnGen.f ====
pnGenPkg.sv
pnGenCfgIf.sv
pnGenRegs.sv
pnGenRate.sv
pnGenSeq.sv
pnGenLfsr.sv
pnGenEncoder.sv
pnGenTop.sv
pnGen_assert.sv
pnGenTb.sv

// ==== Bender.yml ====
package:
  name: pnGen

sources:
  - pnGenPkg.sv
  - pnGenCfgIf.sv
  - pnGenRegs.sv
  - pnGenRate.sv
  - pnGenSeq.sv
  - pnGenLfsr.sv
  - pnGenEncoder.sv
  - pnGenTop.sv
  - target: test
    files:
      - pnGen_assert.sv
      - pnGenTb.sv
